// File: logic/frv_params.svh
/*
 * Uncore constants: the MMIO window, the register offsets inside it and
 * the number of counter slices. Include from any file that needs them.
 */
`ifndef FRV_PARAMS_SVH
`define FRV_PARAMS_SVH

// MMIO window
`define FRV_MMIO_BASE_ADDR 32'h0000_1000
`define FRV_MMIO_BASE_MASK 32'hFFFF_F000

// Register offsets, low half of each 64-bit register
`define FRV_OFF_CYCLE      32'h0000_0000
`define FRV_OFF_TIME       32'h0000_0008
`define FRV_OFF_INSTRET    32'h0000_0010
`define FRV_OFF_MTIMECMP   32'h0000_0018
`define FRV_OFF_HI         32'h0000_0004

`define FRV_NUM_CTR        3

`endif

// File: logic/frv_pkg.sv
/*
 * Types shared by the uncore blocks: word and counter widths, the MMIO
 * request and response structs, interrupt enables and pending bits, and
 * the slice index and interrupt FSM enums. Compile ahead of the RTL.
 */
package frv_pkg;

  // --------------------------------------------------------------------------
  // Plain vectors
  typedef logic [31:0] xlen_t;           // Data and address word
  typedef logic [63:0] ctr_t;            // Full counter value
  typedef logic [5:0]  cause_t;          // Trap cause code

  typedef enum logic [1:0] {
    CTR_CYCLE   = 2'd0,                  // Clock cycles
    CTR_TIME    = 2'd1,                  // Wall time
    CTR_INSTRET = 2'd2                   // Retired instructions
  } ctr_idx_e;

  // --------------------------------------------------------------------------
  // MMIO bus
  typedef struct packed {
    logic  en;                           // Access this cycle
    logic  wen;                          // Write when set, else read
    xlen_t addr;                         // Byte address
    xlen_t wdata;                        // Write data
  } mmio_req_t;

  typedef struct packed {
    xlen_t rdata;                        // Read data, one cycle late
    logic  error;                        // Bad address on last access
  } mmio_rsp_t;

  // --------------------------------------------------------------------------
  // Interrupts
  typedef struct packed {
    logic mie;                           // Global enable
    logic meie;                          // External enable
    logic mtie;                          // Timer enable
    logic msie;                          // Software enable
  } irq_en_t;

  typedef struct packed {
    logic meip;                          // External pending
    logic mtip;                          // Timer pending
    logic msip;                          // Software pending
  } irq_pend_t;

  typedef enum logic {
    INT_IDLE,                            // No trap in flight
    INT_WAIT_ACK                         // Request up, waiting on ack
  } int_state_e;

endpackage

// File: logic/frv_counter_ctrl.sv
/*
 * Counter control. Decodes MMIO writes into one-hot half-write strobes
 * for the counter slices and mtimecmp, and forms the per-slice step
 * enables from the retire pulse and the inhibit levels.
 */
`timescale 1ns/1ps
`include "frv_params.svh"

module frv_counter_ctrl
  import frv_pkg::*;
(
  input  logic                    g_clk,
  input  logic                    rst_n,
  input  mmio_req_t               mmio_req,
  input  logic                    instr_ret,   // Instruction retired
  input  logic                    inhibit_cy,  // Hold cycle
  input  logic                    inhibit_tm,  // Hold time
  input  logic                    inhibit_ir,  // Hold instret
  output logic [`FRV_NUM_CTR-1:0] ctr_wr_lo,
  output logic [`FRV_NUM_CTR-1:0] ctr_wr_hi,
  output logic [`FRV_NUM_CTR-1:0] ctr_step,
  output logic                    cmp_wr_lo,
  output logic                    cmp_wr_hi
);

  xlen_t offset;                                // Address within window
  logic  in_window;
  logic  wr_acc;                                // Write into the window
  logic  ctr_run;                               // Counters out of reset

  assign in_window = (mmio_req.addr & `FRV_MMIO_BASE_MASK) == `FRV_MMIO_BASE_ADDR;
  assign offset    = mmio_req.addr & ~`FRV_MMIO_BASE_MASK;
  assign wr_acc    = mmio_req.en && mmio_req.wen && in_window;

  // --------------------------------------------------------------------------
  // Write strobes, unused offsets raise none
  always_comb begin
    ctr_wr_lo = '0;
    ctr_wr_hi = '0;
    cmp_wr_lo = 1'b0;
    cmp_wr_hi = 1'b0;
    if (wr_acc) begin
      case (offset)
        `FRV_OFF_CYCLE:                  ctr_wr_lo[CTR_CYCLE]   = 1'b1;
        `FRV_OFF_CYCLE + `FRV_OFF_HI:    ctr_wr_hi[CTR_CYCLE]   = 1'b1;
        `FRV_OFF_TIME:                   ctr_wr_lo[CTR_TIME]    = 1'b1;
        `FRV_OFF_TIME + `FRV_OFF_HI:     ctr_wr_hi[CTR_TIME]    = 1'b1;
        `FRV_OFF_INSTRET:                ctr_wr_lo[CTR_INSTRET] = 1'b1;
        `FRV_OFF_INSTRET + `FRV_OFF_HI:  ctr_wr_hi[CTR_INSTRET] = 1'b1;
        `FRV_OFF_MTIMECMP:               cmp_wr_lo              = 1'b1;
        `FRV_OFF_MTIMECMP + `FRV_OFF_HI: cmp_wr_hi              = 1'b1;
        default: ;                              // Error path only
      endcase
    end
  end

  // Counting starts on the first full cycle after reset release
  always_ff @(posedge g_clk) begin
    if (!rst_n) begin
      ctr_run <= 1'b0;
    end else begin
      ctr_run <= 1'b1;
    end
  end

  // --------------------------------------------------------------------------
  // Step enables
  assign ctr_step[CTR_CYCLE]   = ctr_run && !inhibit_cy;
  assign ctr_step[CTR_TIME]    = ctr_run && !inhibit_tm;
  assign ctr_step[CTR_INSTRET] = ctr_run && instr_ret && !inhibit_ir;

endmodule

// File: logic/frv_counter.sv
/*
 * One 64-bit counter slice. Increments on step, or loads the MMIO write
 * data into one 32-bit half. A half write wins over the step, and the
 * carry across the halves is lost in that cycle.
 */
`timescale 1ns/1ps

module frv_counter
  import frv_pkg::*;
(
  input  logic  g_clk,
  input  logic  rst_n,
  input  logic  step,                  // Count this edge
  input  logic  wr_lo,                 // Load bits 31:0
  input  logic  wr_hi,                 // Load bits 63:32
  input  xlen_t wdata,
  output ctr_t  value
);

  ctr_t value_nxt;

  always_comb begin
    value_nxt = value + ctr_t'(step);            // Plain count
    if (wr_lo) begin
      value_nxt = {value[63:32], wdata};         // Upper half keeps, no carry
    end
    if (wr_hi) begin
      value_nxt[63:32] = wdata;                  // Lower half still counts
    end
  end

  always_ff @(posedge g_clk) begin
    if (!rst_n) begin
      value <= '0;
    end else begin
      value <= value_nxt;
    end
  end

endmodule

// File: logic/frv_counter_read.sv
/*
 * Counter read side. Holds mtimecmp, returns registered MMIO read data and
 * the error flag one cycle after each access, and compares the time
 * counter against mtimecmp for the timer interrupt.
 */
`timescale 1ns/1ps
`include "frv_params.svh"

module frv_counter_read
  import frv_pkg::*;
(
  input  logic      g_clk,
  input  logic      rst_n,
  input  mmio_req_t mmio_req,
  input  ctr_t      ctr_value [`FRV_NUM_CTR],   // Slice values
  input  logic      cmp_wr_lo,                  // Load mtimecmp low
  input  logic      cmp_wr_hi,                  // Load mtimecmp high
  output mmio_rsp_t mmio_rsp,
  output logic      timer_pending               // time >= mtimecmp
);

  ctr_t  mtimecmp;
  xlen_t offset;
  xlen_t rd_word;                               // Selected read word
  logic  in_window;
  logic  hit;                                   // One of the eight words

  assign in_window = (mmio_req.addr & `FRV_MMIO_BASE_MASK) == `FRV_MMIO_BASE_ADDR;
  assign offset    = mmio_req.addr & ~`FRV_MMIO_BASE_MASK;

  // --------------------------------------------------------------------------
  // Compare register, all ones keeps the timer quiet
  always_ff @(posedge g_clk) begin
    if (!rst_n) begin
      mtimecmp <= '1;
    end else if (cmp_wr_lo) begin
      mtimecmp[31:0] <= mmio_req.wdata;
    end else if (cmp_wr_hi) begin
      mtimecmp[63:32] <= mmio_req.wdata;
    end
  end

  assign timer_pending = ctr_value[CTR_TIME] >= mtimecmp;

  // --------------------------------------------------------------------------
  // Read decode
  always_comb begin
    hit     = in_window;
    rd_word = '0;
    case (offset)
      `FRV_OFF_CYCLE:                  rd_word = ctr_value[CTR_CYCLE][31:0];
      `FRV_OFF_CYCLE + `FRV_OFF_HI:    rd_word = ctr_value[CTR_CYCLE][63:32];
      `FRV_OFF_TIME:                   rd_word = ctr_value[CTR_TIME][31:0];
      `FRV_OFF_TIME + `FRV_OFF_HI:     rd_word = ctr_value[CTR_TIME][63:32];
      `FRV_OFF_INSTRET:                rd_word = ctr_value[CTR_INSTRET][31:0];
      `FRV_OFF_INSTRET + `FRV_OFF_HI:  rd_word = ctr_value[CTR_INSTRET][63:32];
      `FRV_OFF_MTIMECMP:               rd_word = mtimecmp[31:0];
      `FRV_OFF_MTIMECMP + `FRV_OFF_HI: rd_word = mtimecmp[63:32];
      default:                         hit     = 1'b0;
    endcase
  end

  // Response held until the next access
  always_ff @(posedge g_clk) begin
    if (!rst_n) begin
      mmio_rsp <= '0;
    end else if (mmio_req.en) begin
      mmio_rsp.error <= !hit;
      if (!mmio_req.wen) begin
        mmio_rsp.rdata <= hit ? rd_word : '0;   // Misses read as zero
      end
    end
  end

endmodule

// File: logic/frv_interrupt.sv
/*
 * Interrupt controller. Registers the pending lines, picks one source by
 * fixed priority (NMI, external, software, timer) and holds a trap request
 * with its cause until the pipeline pulses trap_ack.
 */
`timescale 1ns/1ps

module frv_interrupt
  import frv_pkg::*;
(
  input  logic       g_clk,
  input  logic       rst_n,
  input  irq_en_t    irq_en,              // CSR enable bits
  input  logic       int_nmi,             // Non-maskable request
  input  logic       int_external,        // External request
  input  logic       int_software,        // Software request
  input  logic       timer_pending,       // From the timer compare
  input  logic [3:0] int_extern_cause,    // External cause code
  input  logic       trap_ack,            // Trap taken by the pipeline
  output irq_pend_t  mip,
  output logic       trap_req,
  output cause_t     trap_cause
);

  localparam cause_t CAUSE_NMI      = 6'd0;
  localparam cause_t CAUSE_SOFTWARE = 6'd3;
  localparam cause_t CAUSE_TIMER    = 6'd7;
  localparam cause_t CAUSE_EXT_BASE = 6'd16;  // Plus the external code

  int_state_e state;
  int_state_e state_nxt;
  logic       nmi_q;                          // Registered NMI line
  logic [3:0] ext_cause_q;                    // Registered external code
  logic       take_ext;
  logic       take_sw;
  logic       take_tm;
  logic       any_take;                       // Something enabled pending
  cause_t     cause_sel;

  // --------------------------------------------------------------------------
  // Pending registers
  always_ff @(posedge g_clk) begin
    if (!rst_n) begin
      mip   <= '0;
      nmi_q <= 1'b0;
    end else begin
      mip.meip <= int_external;
      mip.mtip <= timer_pending;
      mip.msip <= int_software;
      nmi_q    <= int_nmi;
    end
  end

  always_ff @(posedge g_clk) begin
    ext_cause_q <= int_extern_cause;          // Tracks meip
  end

  // --------------------------------------------------------------------------
  // Priority select
  assign take_ext = mip.meip && irq_en.mie && irq_en.meie;
  assign take_sw  = mip.msip && irq_en.mie && irq_en.msie;
  assign take_tm  = mip.mtip && irq_en.mie && irq_en.mtie;
  assign any_take = nmi_q || take_ext || take_sw || take_tm;

  always_comb begin
    if (nmi_q) begin
      cause_sel = CAUSE_NMI;                  // Ignores mie
    end else if (take_ext) begin
      cause_sel = CAUSE_EXT_BASE + cause_t'(ext_cause_q);
    end else if (take_sw) begin
      cause_sel = CAUSE_SOFTWARE;
    end else begin
      cause_sel = CAUSE_TIMER;
    end
  end

  // --------------------------------------------------------------------------
  // Request and ack FSM
  always_comb begin
    state_nxt = state;
    case (state)
      INT_IDLE:     if (any_take) state_nxt = INT_WAIT_ACK;
      INT_WAIT_ACK: if (trap_ack) state_nxt = INT_IDLE;
      default:      state_nxt = INT_IDLE;
    endcase
  end

  always_ff @(posedge g_clk) begin
    if (!rst_n) begin
      state <= INT_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Cause frozen while the request is up
  always_ff @(posedge g_clk) begin
    if (state == INT_IDLE && any_take) begin
      trap_cause <= cause_sel;
    end
  end

  assign trap_req = state == INT_WAIT_ACK;

endmodule

// File: logic/frv_uncore.sv
/*
 * Uncore top level. Ties the counter control, the three counter slices,
 * the read and compare block and the interrupt controller to the pipeline
 * side MMIO bus, counter controls and trap handshake.
 */
`timescale 1ns/1ps
`include "frv_params.svh"

module frv_uncore
  import frv_pkg::*;
(
  input  logic       g_clk,              // Global clock
  input  logic       rst_n,              // Synchronous reset
  input  mmio_req_t  mmio_req,           // MMIO access from the pipeline
  output mmio_rsp_t  mmio_rsp,           // MMIO reply
  input  logic       instr_ret,          // Instruction retired
  input  logic       inhibit_cy,         // Stop cycle counting
  input  logic       inhibit_tm,         // Stop time counting
  input  logic       inhibit_ir,         // Stop instret counting
  input  irq_en_t    irq_en,             // Interrupt enables
  output logic       trap_req,           // Interrupt trap request
  output cause_t     trap_cause,         // Its cause
  input  logic       trap_ack,           // Trap taken
  input  logic       int_nmi,            // Non-maskable interrupt
  input  logic       int_external,       // External interrupt line
  input  logic [3:0] int_extern_cause,   // External cause code
  input  logic       int_software,       // Software interrupt line
  output logic       int_mtime           // Timer interrupt pending
);

  // --------------------------------------------------------------------------
  logic [`FRV_NUM_CTR-1:0] ctr_wr_lo;    // Per slice low half write
  logic [`FRV_NUM_CTR-1:0] ctr_wr_hi;    // Per slice high half write
  logic [`FRV_NUM_CTR-1:0] ctr_step;     // Per slice count enable
  logic                    cmp_wr_lo;
  logic                    cmp_wr_hi;
  ctr_t                    ctr_value [`FRV_NUM_CTR];
  logic                    timer_pending;
  irq_pend_t               mip;

  assign int_mtime = mip.mtip;

  // --------------------------------------------------------------------------
  frv_counter_ctrl u_ctrl (
    .g_clk      (g_clk),
    .rst_n      (rst_n),
    .mmio_req   (mmio_req),
    .instr_ret  (instr_ret),
    .inhibit_cy (inhibit_cy),
    .inhibit_tm (inhibit_tm),
    .inhibit_ir (inhibit_ir),
    .ctr_wr_lo  (ctr_wr_lo),
    .ctr_wr_hi  (ctr_wr_hi),
    .ctr_step   (ctr_step),
    .cmp_wr_lo  (cmp_wr_lo),
    .cmp_wr_hi  (cmp_wr_hi)
  );

  // Cycle, time and instret slices
  for (genvar i = 0; i < `FRV_NUM_CTR; i++) begin : g_ctr
    frv_counter u_ctr (
      .g_clk (g_clk),
      .rst_n (rst_n),
      .step  (ctr_step[i]),
      .wr_lo (ctr_wr_lo[i]),
      .wr_hi (ctr_wr_hi[i]),
      .wdata (mmio_req.wdata),           // Shared write data
      .value (ctr_value[i])
    );
  end

  frv_counter_read u_read (
    .g_clk         (g_clk),
    .rst_n         (rst_n),
    .mmio_req      (mmio_req),
    .ctr_value     (ctr_value),
    .cmp_wr_lo     (cmp_wr_lo),
    .cmp_wr_hi     (cmp_wr_hi),
    .mmio_rsp      (mmio_rsp),
    .timer_pending (timer_pending)
  );

  frv_interrupt u_int (
    .g_clk            (g_clk),
    .rst_n            (rst_n),
    .irq_en           (irq_en),
    .int_nmi          (int_nmi),
    .int_external     (int_external),
    .int_software     (int_software),
    .timer_pending    (timer_pending),
    .int_extern_cause (int_extern_cause),
    .trap_ack         (trap_ack),
    .mip              (mip),
    .trap_req         (trap_req),
    .trap_cause       (trap_cause)
  );

endmodule

// File: verif/frv_uncore_tb.sv
/*
 * Testbench for the uncore. Replays the command file in verif/ one line at
 * a time: MMIO writes and reads, idle gaps, input level changes and trap
 * checks. Run from the project root with the file list.
 */
`timescale 1ns/1ps

module frv_uncore_tb
  import frv_pkg::*;
();

  localparam IN_FILE = "verif/frv_uncore_input.txt";
  localparam int unsigned SEED = 32'hf257d531;
  localparam int TRAP_WAIT  = 32;                // Cycles allowed for trap_req
  localparam int QUIET_WAIT = 8;                 // Cycles watched for no trap

  logic       g_clk;
  logic       rst_n;
  mmio_req_t  mmio_req;
  mmio_rsp_t  mmio_rsp;
  logic       instr_ret;
  logic       inhibit_cy;
  logic       inhibit_tm;
  logic       inhibit_ir;
  irq_en_t    irq_en;
  logic       trap_req;
  cause_t     trap_cause;
  logic       trap_ack;
  logic       int_nmi;
  logic       int_external;
  logic [3:0] int_extern_cause;
  logic       int_software;
  logic       int_mtime;

  int               fd;
  int               n_tok;
  int               line_no;
  int               limit_cycles;                // Zero until the file is sized
  int unsigned      gap;
  int unsigned      seed_val;
  logic [8*128-1:0] line_buf;
  logic [8*8-1:0]   cmd;
  logic [8*24-1:0]  arg_name;                    // SET signal name
  logic [8*24-1:0]  test_name;                   // Last section comment
  logic [31:0]      arg_a;
  logic [31:0]      arg_b;

  frv_uncore u_dut (
    .g_clk            (g_clk),
    .rst_n            (rst_n),
    .mmio_req         (mmio_req),
    .mmio_rsp         (mmio_rsp),
    .instr_ret        (instr_ret),
    .inhibit_cy       (inhibit_cy),
    .inhibit_tm       (inhibit_tm),
    .inhibit_ir       (inhibit_ir),
    .irq_en           (irq_en),
    .trap_req         (trap_req),
    .trap_cause       (trap_cause),
    .trap_ack         (trap_ack),
    .int_nmi          (int_nmi),
    .int_external     (int_external),
    .int_extern_cause (int_extern_cause),
    .int_software     (int_software),
    .int_mtime        (int_mtime)
  );

  initial begin
    g_clk = 1'b0;
    forever #4 g_clk = ~g_clk;                   // 8 ns period
  end

  // --------------------------------------------------------------------------
  // Failure reporting
  task automatic report_mismatch(input logic [8*24-1:0] name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("CHECK FAILED %0s (line %0d): expected %h actual %h", name, line_no, exp, act);
    $display("Result: FAILED");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic abort_run(input string msg);
    $display("ERROR: %0s", msg);
    $display("Result: FAILED");
    $fatal(1, "run aborted");
  endtask

  // --------------------------------------------------------------------------
  // Bus and signal drivers
  task automatic mmio_access(input logic wen, input xlen_t addr, input xlen_t wdata);
    @(posedge g_clk);
    mmio_req.en    <= 1'b1;
    mmio_req.wen   <= wen;
    mmio_req.addr  <= addr;
    mmio_req.wdata <= wdata;
    @(posedge g_clk);                            // DUT samples the access here
    mmio_req.en    <= 1'b0;
    mmio_req.wen   <= 1'b0;
    @(negedge g_clk);                            // Reply settled
  endtask

  task automatic set_signal(input logic [8*24-1:0] name, input logic [31:0] val);
    @(posedge g_clk);
    case (name)
      "instr_ret":        instr_ret        <= val[0];
      "inhibit_cy":       inhibit_cy       <= val[0];
      "inhibit_tm":       inhibit_tm       <= val[0];
      "inhibit_ir":       inhibit_ir       <= val[0];
      "irq_en":           irq_en           <= irq_en_t'(val[3:0]);  // mie meie mtie msie
      "int_nmi":          int_nmi          <= val[0];
      "int_external":     int_external     <= val[0];
      "int_extern_cause": int_extern_cause <= val[3:0];
      "int_software":     int_software     <= val[0];
      default:            abort_run("unknown signal name in a SET command");
    endcase
  endtask

  // --------------------------------------------------------------------------
  // Trap handshake
  task automatic take_trap(input cause_t exp_cause);
    int waited;
    waited = 0;
    @(negedge g_clk);
    while (!trap_req) begin
      if (waited == TRAP_WAIT) begin
        abort_run("trap_req did not rise within the trap wait limit");
      end
      waited++;
      @(negedge g_clk);
    end
    assert (trap_cause == exp_cause) else report_mismatch(test_name, exp_cause, trap_cause);
    if (exp_cause == 6'd7) begin                 // Timer still past mtimecmp
      assert (int_mtime) else report_mismatch(test_name, 1, int_mtime);
    end
    @(posedge g_clk);
    trap_ack <= 1'b1;                            // One cycle ack pulse
    @(posedge g_clk);
    trap_ack <= 1'b0;
  endtask

  task automatic watch_quiet();
    @(posedge g_clk);
    repeat (QUIET_WAIT) begin
      @(negedge g_clk);
      assert (!trap_req) else report_mismatch(test_name, 0, trap_req);
    end
  endtask

  // Watchdog length from the line count and the longest idle gaps
  task automatic size_watchdog();
    int lines;
    int idle_sum;
    int n_lo;
    int n_hi;
    lines    = 0;
    idle_sum = 0;
    fd = $fopen(IN_FILE, "r");
    if (fd == 0) begin
      abort_run("cannot open the input file");
    end
    while ($fgets(line_buf, fd) != 0) begin
      lines++;
      cmd   = '0;
      n_tok = $sscanf(line_buf, "%s %d %d", cmd, n_lo, n_hi);
      if (cmd == "IDLE") begin
        idle_sum += (n_tok < 3) ? n_lo : n_hi;
      end
    end
    $fclose(fd);
    limit_cycles = 20 * lines + idle_sum;
  endtask

  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge g_clk);
    abort_run("watchdog expired before the input file was replayed");
  end

  // --------------------------------------------------------------------------
  // Replay
  initial begin
    rst_n            = 1'b0;
    mmio_req         = '0;
    instr_ret        = 1'b0;
    inhibit_cy       = 1'b0;
    inhibit_tm       = 1'b0;
    inhibit_ir       = 1'b0;
    irq_en           = '0;
    trap_ack         = 1'b0;
    int_nmi          = 1'b0;
    int_external     = 1'b0;
    int_extern_cause = 4'd0;
    int_software     = 1'b0;
    limit_cycles     = 0;
    line_no          = 0;
    test_name        = "reset";
    seed_val         = $urandom(SEED);
    size_watchdog();
    repeat (2) @(posedge g_clk);
    rst_n <= 1'b1;
    repeat (2) @(negedge g_clk);                 // First edge out of reset has loaded mip
    assert (mmio_rsp.rdata == '0) else report_mismatch(test_name, 0, mmio_rsp.rdata);
    assert (!mmio_rsp.error) else report_mismatch(test_name, 0, mmio_rsp.error);
    assert (!trap_req) else report_mismatch(test_name, 0, trap_req);
    assert (!int_mtime) else report_mismatch(test_name, 0, int_mtime);

    fd = $fopen(IN_FILE, "r");
    while ($fgets(line_buf, fd) != 0) begin
      line_no++;
      cmd   = '0;
      n_tok = $sscanf(line_buf, "%s", cmd);
      case (cmd)
        "#": n_tok = $sscanf(line_buf, "%s %s", cmd, test_name);  // Section name
        "WR": begin
          n_tok = $sscanf(line_buf, "%s %h %h", cmd, arg_a, arg_b);
          mmio_access(1'b1, arg_a, arg_b);
          assert (!mmio_rsp.error) else report_mismatch(test_name, 0, mmio_rsp.error);
        end
        "RD": begin
          n_tok = $sscanf(line_buf, "%s %h %h", cmd, arg_a, arg_b);
          mmio_access(1'b0, arg_a, '0);
          assert (mmio_rsp.rdata == arg_b) else report_mismatch(test_name, arg_b, mmio_rsp.rdata);
          assert (!mmio_rsp.error) else report_mismatch(test_name, 0, mmio_rsp.error);
        end
        "RDERR": begin
          n_tok = $sscanf(line_buf, "%s %h", cmd, arg_a);
          mmio_access(1'b0, arg_a, '0);
          assert (mmio_rsp.error) else report_mismatch(test_name, 1, mmio_rsp.error);
        end
        "IDLE": begin
          n_tok = $sscanf(line_buf, "%s %d %d", cmd, arg_a, arg_b);
          if (n_tok < 3) begin
            arg_b = arg_a;                       // Fixed gap
          end
          gap = arg_a + ($urandom % (arg_b - arg_a + 1));
          repeat (gap) @(posedge g_clk);
        end
        "SET": begin
          n_tok = $sscanf(line_buf, "%s %s %h", cmd, arg_name, arg_a);
          set_signal(arg_name, arg_a);
        end
        "TRAP": begin
          n_tok = $sscanf(line_buf, "%s %d", cmd, arg_a);
          take_trap(cause_t'(arg_a));
        end
        "NOTRAP": watch_quiet();
        default: begin
          if (cmd != '0) begin
            abort_run("unknown command in the input file");
          end
        end
      endcase
    end
    $fclose(fd);

    $display("Result: PASSED");
    $finish;
  end

endmodule

// File: verif/frv_uncore_input.txt
# columns: command, then address, signal name or gap, then data, expected
# value, new level or gap upper bound; lines starting with # name a section
# write_read
WR 00001004 00000001
WR 00001000 fffffff0
RD 00001000 fffffff1
RD 00001004 00000001
IDLE 14
RD 00001004 00000002
RD 00001000 00000005
WR 00001014 00000000
WR 00001010 12345678
RD 00001010 12345678
RD 00001014 00000000
WR 0000100c 00000003
WR 00001008 00000000
RD 00001008 00000001
RD 0000100c 00000003
RD 00001018 ffffffff
RD 0000101c ffffffff
# free_run
WR 00001000 00000100
IDLE 5
RD 00001000 00000106
IDLE 9
RD 00001000 00000111
WR 00001008 00000200
IDLE 3
RD 00001008 00000204
RD 00001008 00000206
# inhibit_retire
SET inhibit_cy 1
WR 00001000 00000055
IDLE 3 12
RD 00001000 00000055
IDLE 3 12
RD 00001000 00000055
SET inhibit_cy 0
RD 00001000 00000056
SET inhibit_ir 1
SET instr_ret 1
IDLE 3
SET instr_ret 0
SET inhibit_ir 0
RD 00001010 12345678
SET instr_ret 1
SET instr_ret 0
SET instr_ret 1
IDLE 2
SET instr_ret 0
RD 00001010 1234567c
# errors
SET inhibit_cy 1
SET inhibit_tm 1
WR 00001000 00000aaa
WR 00001008 00000bbb
RDERR 00002000
RDERR 00001020
RDERR 00000008
RDERR 00001002
IDLE 0 8
RD 00001000 00000aaa
RD 00001008 00000bbb
RD 00001010 1234567c
SET inhibit_tm 0
SET inhibit_cy 0
# timer
SET irq_en a
WR 0000100c 00000000
WR 00001008 00000000
WR 0000101c 00000000
WR 00001018 00000014
NOTRAP
IDLE 16 24
SET irq_en 0
TRAP 7
WR 0000101c ffffffff
WR 00001018 ffffffff
SET irq_en a
NOTRAP
SET irq_en 0
# priority
SET int_extern_cause 5
SET int_external 1
SET int_software 1
SET int_nmi 1
SET int_nmi 0
TRAP 0
SET irq_en d
SET int_external 0
TRAP 21
SET int_software 0
TRAP 3
NOTRAP
# disabled
SET irq_en 5
SET int_software 1
SET int_external 1
NOTRAP
SET int_software 0
SET int_external 0
SET irq_en 0

// File: vlog.f
+incdir+logic
logic/frv_pkg.sv
logic/frv_counter_ctrl.sv
logic/frv_counter.sv
logic/frv_counter_read.sv
logic/frv_interrupt.sv
logic/frv_uncore.sv
verif/frv_uncore_tb.sv
